// File: bench/rv_core_vectors.hex
// Word 0 is the program size, then the program words from address 0,
// then the store count, then the expected store address and data pairs in order
0000005E
// 0x000 setup x1 = -20, x2 = 3, x10 = 0x100
FEC00093 00300113 10000513
// 0x00C reg-reg add sub sll slt sltu xor srl sra or and, stored at 0x100
002081B3 00352023 402081B3 00352223 002091B3 00352423
0020A1B3 00352623 0020B1B3 00352823 0020C1B3 00352A23
0020D1B3 00352C23 4020D1B3 00352E23 0020E1B3 02352023
0020F1B3 02352223
// 0x05C addi slti xori andi slli srli srai lui auipc, stored at 0x140
06408213 04452023 FED0A293 04552223 FFF0C393 04752423
07F0F493 04952623 00409593 04B52823 0040D613 04C52A23
4040D693 04D52C23 12345737 04E52E23 00001797 06F52023
// 0x0A4 dependent chain one and two apart, stored at 0x180
00210833 002808B3 01180933 002919B3 09352023 09252223 09152423
// 0x0C0 loads with an immediate consumer, stored at 0x1C0
00052A03 001A0A93 0D552023 01C52B03 0D652223 04052B83 017B8C33 0D852423
// 0x0E0 taken branch over a poison store, untaken branch into x25++
00210463 1E152823 00208463 001C8C93
00209463 1E152823 00109463 001C8C93
0020C463 1E152823 00114463 001C8C93
00115463 1E152823 0020D463 001C8C93
00116463 1E152823 0020E463 001C8C93
0020F463 1E152823 00117463 001C8C93
// 0x140 countdown loop with a backward bne, then store x25 and x27
00300D13 005D8D93 FFFD0D13 FE0D1CE3 11952023 11B52223
// 0x158 jal and jalr over poison stores, store both links, then spin
00800E6F 1E152823 16900E93 004E8F67 1E152823 11C52423 11E52623 0000006F
// Expected stores
0000001D
00000100 FFFFFFEF 00000104 FFFFFFE9 00000108 FFFFFF60
0000010C 00000001 00000110 00000000 00000114 FFFFFFEF
00000118 1FFFFFFD 0000011C FFFFFFFD 00000120 FFFFFFEF
00000124 00000000
00000140 00000050 00000144 00000001 00000148 00000013
0000014C 0000006C 00000150 FFFFFEC0 00000154 0FFFFFFE
00000158 FFFFFFFE 0000015C 12345000 00000160 0000109C
00000180 00000078 00000184 0000000F 00000188 00000009
000001C0 FFFFFFF0 000001C4 FFFFFFFD 000001C8 000000A0
00000200 00000006 00000204 0000000F 00000208 0000015C
0000020C 00000168

// File: list.f
verilog/rv_core_pkg.sv
verilog/rv_isa_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_hazard_unit.sv
verilog/rv_core_top.sv
bench/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f list.f \
  --Mdir obj_dir -o tb_rv_core_sim &&
  ./obj_dir/tb_rv_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "tb_rv_core: pass" ||
  { echo "tb_rv_core: fail"; exit 1; }

// File: bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  import rv_core_pkg::*;

  localparam int          VEC_DEPTH      = 256;
  localparam int          DMEM_WORDS     = 256;
  localparam int          STORE_TIMEOUT  = 5000;
  localparam int          DRAIN_CYCLES   = 100;
  localparam logic [31:0] LCG_SEED       = 32'h8ec2_2f2e;
  // sw x1, 0x1f0(x10), an address that no expected store uses
  localparam word_t       IMEM_IDLE_WORD = 32'h1E15_2823;
  localparam word_t       DMEM_IDLE_WORD = 32'hDEAD_BEEF;

  logic        clk        = 1'b0;
  logic        rst_n      = 1'b0;
  logic        imem_ready = 1'b1;
  logic        dmem_ready = 1'b1;
  logic [31:0] lcg_state  = LCG_SEED;

  word_t imem_addr;
  logic  imem_read;
  word_t imem_data;
  word_t fetch_idx;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_read;
  logic  dmem_write;
  word_t dmem_rdata;

  // Count, program words, store count, then address and data pairs
  word_t vectors [VEC_DEPTH];
  word_t dmem [DMEM_WORDS] = '{default: '0};
  int    inst_count  = 0;
  int    store_count = 0;
  int    store_base  = 0;
  int    store_idx   = 0;

  always #5 clk = ~clk;

  rv_core_top rv_core_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr_o  (imem_addr),
    .imem_read_o  (imem_read),
    .imem_data_i  (imem_data),
    .imem_ready_i (imem_ready),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_read_o  (dmem_read),
    .dmem_write_o (dmem_write),
    .dmem_rdata_i (dmem_rdata),
    .dmem_ready_i (dmem_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t vec_word(input int pos);
    logic [7:0] idx;
    idx = pos[7:0];
    return vectors[idx];
  endfunction

  // Each program section stores into its own 64-byte region
  function automatic string behavior_name(input word_t addr);
    case (addr[9:6])
      4'h4:    return "alu_reg_reg";
      4'h5:    return "alu_imm_upper";
      4'h6:    return "forwarding";
      4'h7:    return "load_use";
      4'h8:    return "branch_jump";
      default: return "unknown_region";
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_store(input int idx, input word_t addr, input word_t data);
    word_t exp_addr;
    word_t exp_data;
    string name;
    assert (idx < store_count) else
      fail_run($sformatf("Store %0d to 0x%08h came after all %0d expected stores",
                         idx, addr, store_count));
    exp_addr = vec_word(store_base + 2 * idx);
    exp_data = vec_word(store_base + 2 * idx + 1);
    name     = behavior_name(exp_addr);
    assert (addr == exp_addr) else
      fail_run($sformatf("FAILED %s store %0d address: expected 0x%08h actual 0x%08h",
                         name, idx, exp_addr, addr));
    assert (data == exp_data) else
      fail_run($sformatf("FAILED %s store %0d data: expected 0x%08h actual 0x%08h",
                         name, idx, exp_data, data));
  endtask

  // ========================================
  // Memory models
  // ========================================
  assign fetch_idx = imem_addr >> 2;

  // Read data is only valid while a read is requested
  assign dmem_rdata = dmem_read ? dmem[dmem_addr[9:2]] : DMEM_IDLE_WORD;

  // Past the program end the fetch sees NOPs
  always_comb begin
    if (!imem_read) begin
      imem_data = IMEM_IDLE_WORD;
    end else if (fetch_idx < word_t'(inst_count)) begin
      imem_data = vec_word(int'(fetch_idx) + 1);
    end else begin
      imem_data = NOP_WORD;
    end
  end

  // Ready is low about one cycle in four on each memory
  always @(posedge clk) begin
    lcg_state  <= lcg_next(lcg_state);
    imem_ready <= (lcg_state[31:30] != 2'b00);
    dmem_ready <= (lcg_state[29:28] != 2'b00);
  end

  // A write completes in the cycle its ready is high
  always @(posedge clk) begin
    if (rst_n && dmem_write && dmem_ready) begin
      check_store(store_idx, dmem_addr, dmem_wdata);
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      store_idx            <= store_idx + 1;
    end
  end

  // ========================================
  // Sequence
  // ========================================
  initial begin : main_seq
    int cycles;
    $readmemh("bench/rv_core_vectors.hex", vectors);
    assert (!$isunknown(vectors[0])) else
      fail_run("The vector file bench/rv_core_vectors.hex could not be read");
    inst_count = int'(vectors[0]);
    assert (inst_count > 0 && inst_count < VEC_DEPTH - 2) else
      fail_run($sformatf("The vector file gives an impossible program size of %0d",
                         inst_count));
    store_count = int'(vec_word(inst_count + 1));
    store_base  = inst_count + 2;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    cycles = 0;
    while (store_idx < store_count && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (store_idx >= store_count) else
      fail_run($sformatf("Timeout: only %0d of %0d expected stores arrived in %0d cycles",
                         store_idx, store_count, STORE_TIMEOUT));

    // Program ends in a self loop, any later store is a stray one
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic                clk,
  input  logic                rst_n,
  output rv_core_pkg::word_t  imem_addr_o,
  output logic                imem_read_o,
  input  rv_core_pkg::word_t  imem_data_i,
  input  logic                imem_ready_i,
  output rv_core_pkg::word_t  dmem_addr_o,
  output rv_core_pkg::word_t  dmem_wdata_o,
  output logic                dmem_read_o,
  output logic                dmem_write_o,
  input  rv_core_pkg::word_t  dmem_rdata_i,
  input  logic                dmem_ready_i
);

  import rv_core_pkg::*;

  // Fetch stage
  word_t pc;
  word_t f_pc;
  word_t f_inst;
  logic  f_valid;

  // Decode/execute stage
  reg_idx_t                 rs1;
  reg_idx_t                 rs2;
  reg_idx_t                 rd;
  rv_isa_pkg::alu_op_e      alu_op;
  logic                     use_imm;
  word_t                    imm;
  logic                     reg_write;
  logic                     mem_read;
  logic                     mem_write;
  logic                     branch;
  rv_isa_pkg::branch_cond_e branch_cond;
  logic                     jal;
  logic                     jalr;
  logic                     uses_rs1;
  logic                     uses_rs2;
  word_t                    rf_a;
  word_t                    rf_b;
  word_t                    ex_result;
  word_t                    ex_store_data;
  logic                     redirect;
  word_t                    target;

  // Memory stage
  logic     m_valid;
  logic     m_reg_write;
  logic     m_mem_read;
  logic     m_mem_write;
  logic     m_done;
  reg_idx_t m_rd;
  word_t    m_result;
  word_t    m_store_data;
  logic     dmem_req;

  // Writeback stage
  logic     w_valid;
  logic     w_reg_write;
  reg_idx_t w_rd;
  word_t    w_result;

  logic stall;
  logic bubble;
  logic fetch_ready;

  // ========================================
  // Fetch
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imem_read_o <= 1'b0;
    end else begin
      imem_read_o <= 1'b1;
    end
  end

  // No fetch in flight right after reset
  assign fetch_ready = imem_ready_i || !imem_read_o;
  assign imem_addr_o = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall && !bubble && imem_read_o) begin
      pc <= redirect ? target : pc + XLEN'(4);
    end
  end

  // Squash the word fetched behind a taken branch or jump
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      f_valid <= 1'b0;
      f_inst  <= NOP_WORD;
    end else if (!stall && !bubble) begin
      if (redirect) begin
        f_valid <= 1'b0;
        f_inst  <= NOP_WORD;
      end else begin
        f_valid <= imem_read_o;
        f_inst  <= imem_data_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && !bubble) begin
      f_pc <= pc;
    end
  end

  // ========================================
  // Decode/execute
  // ========================================
  rv_decoder rv_decoder_i (
    .inst_i        (f_inst),
    .valid_i       (f_valid),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .alu_op_o      (alu_op),
    .use_imm_o     (use_imm),
    .imm_o         (imm),
    .reg_write_o   (reg_write),
    .mem_read_o    (mem_read),
    .mem_write_o   (mem_write),
    .branch_o      (branch),
    .branch_cond_o (branch_cond),
    .jal_o         (jal),
    .jalr_o        (jalr),
    .uses_rs1_o    (uses_rs1),
    .uses_rs2_o    (uses_rs2)
  );

  // Written at the end of writeback, held off while frozen
  rv_regfile rv_regfile_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (w_rd),
    .wdata_i   (w_result),
    .we_i      (w_valid && w_reg_write && !stall),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b)
  );

  rv_execute rv_execute_i (
    .pc_i            (f_pc),
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .rf_a_i          (rf_a),
    .rf_b_i          (rf_b),
    .alu_op_i        (alu_op),
    .use_imm_i       (use_imm),
    .imm_i           (imm),
    .branch_i        (branch),
    .branch_cond_i   (branch_cond),
    .jal_i           (jal),
    .jalr_i          (jalr),
    .mem_fwd_valid_i (m_valid && m_reg_write && !m_mem_read),
    .mem_fwd_rd_i    (m_rd),
    .mem_fwd_data_i  (m_result),
    .wb_fwd_valid_i  (w_valid && w_reg_write),
    .wb_fwd_rd_i     (w_rd),
    .wb_fwd_data_i   (w_result),
    .result_o        (ex_result),
    .store_data_o    (ex_store_data),
    .redirect_o      (redirect),
    .target_o        (target)
  );

  rv_hazard_unit rv_hazard_unit_i (
    .mem_load_i    (m_valid && m_mem_read),
    .mem_access_i  (dmem_req),
    .mem_rd_i      (m_rd),
    .ex_valid_i    (f_valid),
    .ex_rs1_i      (rs1),
    .ex_rs2_i      (rs2),
    .ex_uses_rs1_i (uses_rs1),
    .ex_uses_rs2_i (uses_rs2),
    .imem_ready_i  (fetch_ready),
    .dmem_ready_i  (dmem_ready_i),
    .stall_o       (stall),
    .bubble_o      (bubble)
  );

  // ========================================
  // Memory
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid     <= 1'b0;
      m_reg_write <= 1'b0;
      m_mem_read  <= 1'b0;
      m_mem_write <= 1'b0;
    end else if (!stall) begin
      m_valid     <= f_valid && !bubble;
      m_reg_write <= reg_write && !bubble;
      m_mem_read  <= mem_read && !bubble;
      m_mem_write <= mem_write && !bubble;
    end
  end

  // Access already accepted while the fetch side holds the pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_done <= 1'b0;
    end else if (!stall) begin
      m_done <= 1'b0;
    end else if (dmem_req && dmem_ready_i) begin
      m_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      m_rd         <= rd;
      m_result     <= ex_result;
      m_store_data <= ex_store_data;
    end else if (dmem_read_o && dmem_ready_i) begin
      // Address no longer needed, keep the load data
      m_result <= dmem_rdata_i;
    end
  end

  assign dmem_req     = m_valid && (m_mem_read || m_mem_write) && !m_done;
  assign dmem_addr_o  = m_result;
  assign dmem_wdata_o = m_store_data;
  assign dmem_read_o  = dmem_req && m_mem_read;
  assign dmem_write_o = dmem_req && m_mem_write;

  // ========================================
  // Writeback
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_valid     <= 1'b0;
      w_reg_write <= 1'b0;
    end else if (!stall) begin
      w_valid     <= m_valid;
      w_reg_write <= m_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      w_rd     <= m_rd;
      w_result <= (m_mem_read && !m_done) ? dmem_rdata_i : m_result;
    end
  end

endmodule

// File: verilog/rv_hazard_unit.sv
`timescale 1ns/1ps

module rv_hazard_unit (
  input  logic                   mem_load_i,
  input  logic                   mem_access_i,
  input  rv_core_pkg::reg_idx_t  mem_rd_i,
  input  logic                   ex_valid_i,
  input  rv_core_pkg::reg_idx_t  ex_rs1_i,
  input  rv_core_pkg::reg_idx_t  ex_rs2_i,
  input  logic                   ex_uses_rs1_i,
  input  logic                   ex_uses_rs2_i,
  input  logic                   imem_ready_i,
  input  logic                   dmem_ready_i,
  output logic                   stall_o,
  output logic                   bubble_o
);

  import rv_core_pkg::*;

  logic rs1_match;
  logic rs2_match;
  logic load_use;

  assign rs1_match = ex_uses_rs1_i && (ex_rs1_i == mem_rd_i);
  assign rs2_match = ex_uses_rs2_i && (ex_rs2_i == mem_rd_i);

  // Load data only exists in the memory stage, one cycle too late
  assign load_use = mem_load_i && ex_valid_i && (mem_rd_i != reg_idx_t'(0)) &&
                    (rs1_match || rs2_match);

  // Either memory not ready freezes the whole pipeline
  assign stall_o  = !imem_ready_i || (mem_access_i && !dmem_ready_i);
  assign bubble_o = load_use && !stall_o;

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::word_t        pc_i,
  input  rv_core_pkg::reg_idx_t     rs1_i,
  input  rv_core_pkg::reg_idx_t     rs2_i,
  input  rv_core_pkg::word_t        rf_a_i,
  input  rv_core_pkg::word_t        rf_b_i,
  input  rv_isa_pkg::alu_op_e       alu_op_i,
  input  logic                      use_imm_i,
  input  rv_core_pkg::word_t        imm_i,
  input  logic                      branch_i,
  input  rv_isa_pkg::branch_cond_e  branch_cond_i,
  input  logic                      jal_i,
  input  logic                      jalr_i,
  input  logic                      mem_fwd_valid_i,
  input  rv_core_pkg::reg_idx_t     mem_fwd_rd_i,
  input  rv_core_pkg::word_t        mem_fwd_data_i,
  input  logic                      wb_fwd_valid_i,
  input  rv_core_pkg::reg_idx_t     wb_fwd_rd_i,
  input  rv_core_pkg::word_t        wb_fwd_data_i,
  output rv_core_pkg::word_t        result_o,
  output rv_core_pkg::word_t        store_data_o,
  output logic                      redirect_o,
  output rv_core_pkg::word_t        target_o
);

  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      alu_b;
  word_t      alu_res;
  word_t      jalr_sum;
  logic [4:0] shamt;
  logic       cond_true;

  // Youngest producer wins, x0 is never forwarded
  function automatic word_t forward(input reg_idx_t src, input word_t rf_data);
    word_t data;
    data = rf_data;
    if (src != '0) begin
      if (mem_fwd_valid_i && mem_fwd_rd_i == src) begin
        data = mem_fwd_data_i;
      end else if (wb_fwd_valid_i && wb_fwd_rd_i == src) begin
        data = wb_fwd_data_i;
      end
    end
    return data;
  endfunction

  always_comb begin
    op_a = forward(rs1_i, rf_a_i);
    op_b = forward(rs2_i, rf_b_i);
  end

  // ========================================
  // ALU
  // ========================================
  assign alu_b = use_imm_i ? imm_i : op_b;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_SUB:       alu_res = op_a - alu_b;
      ALU_SLL:       alu_res = op_a << shamt;
      ALU_SLT:       alu_res = word_t'($signed(op_a) < $signed(alu_b));
      ALU_SLTU:      alu_res = word_t'(op_a < alu_b);
      ALU_XOR:       alu_res = op_a ^ alu_b;
      ALU_SRL:       alu_res = op_a >> shamt;
      ALU_SRA:       alu_res = $signed(op_a) >>> shamt;
      ALU_OR:        alu_res = op_a | alu_b;
      ALU_AND:       alu_res = op_a & alu_b;
      ALU_PASS_B:    alu_res = alu_b;
      ALU_PC_PLUS_B: alu_res = pc_i + alu_b;
      default:       alu_res = op_a + alu_b;
    endcase
  end

  // Jumps write the link address instead
  assign result_o     = (jal_i || jalr_i) ? pc_i + XLEN'(4) : alu_res;
  assign store_data_o = op_b;

  // ========================================
  // Branch resolution
  // ========================================
  always_comb begin
    case (branch_cond_i)
      BR_EQ:   cond_true = (op_a == op_b);
      BR_NE:   cond_true = (op_a != op_b);
      BR_LT:   cond_true = ($signed(op_a) < $signed(op_b));
      BR_GE:   cond_true = ($signed(op_a) >= $signed(op_b));
      BR_LTU:  cond_true = (op_a < op_b);
      BR_GEU:  cond_true = (op_a >= op_b);
      default: cond_true = 1'b0;
    endcase
  end

  assign jalr_sum   = op_a + imm_i;
  assign redirect_o = jal_i || jalr_i || (branch_i && cond_true);

  // Branch and JAL both use PC plus their own immediate
  assign target_o = jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::reg_idx_t  raddr_a_i,
  input  rv_core_pkg::reg_idx_t  raddr_b_i,
  input  rv_core_pkg::reg_idx_t  waddr_i,
  input  rv_core_pkg::word_t     wdata_i,
  input  logic                   we_i,
  output rv_core_pkg::word_t     rdata_a_o,
  output rv_core_pkg::word_t     rdata_b_o
);

  import rv_core_pkg::*;

  word_t regs [REG_COUNT];

  // x0 keeps its reset value forever
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_core_pkg::word_t        inst_i,
  input  logic                      valid_i,
  output rv_core_pkg::reg_idx_t     rs1_o,
  output rv_core_pkg::reg_idx_t     rs2_o,
  output rv_core_pkg::reg_idx_t     rd_o,
  output rv_isa_pkg::alu_op_e       alu_op_o,
  output logic                      use_imm_o,
  output rv_core_pkg::word_t        imm_o,
  output logic                      reg_write_o,
  output logic                      mem_read_o,
  output logic                      mem_write_o,
  output logic                      branch_o,
  output rv_isa_pkg::branch_cond_e  branch_cond_o,
  output logic                      jal_o,
  output logic                      jalr_o,
  output logic                      uses_rs1_o,
  output logic                      uses_rs2_o
);

  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       op_ok;
  logic       op_imm_ok;
  imm_fmt_e   imm_fmt;

  // Shared ALU selection for OP and OP_IMM
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[FUNCT3_LSB +: 3];
  assign funct7 = inst_i[FUNCT7_LSB +: 7];

  assign rs1_o         = inst_i[RS1_LSB +: $bits(reg_idx_t)];
  assign rs2_o         = inst_i[RS2_LSB +: $bits(reg_idx_t)];
  assign rd_o          = inst_i[RD_LSB +: $bits(reg_idx_t)];
  assign branch_cond_o = branch_cond_e'(funct3);

  // M extension funct7 falls out here
  assign op_ok = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  // Only shift immediates constrain the upper bits
  assign op_imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                     (funct3 != 3'b101 || funct7 == 7'b0000000 || funct7 == 7'b0100000);

  always_comb begin
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    imm_fmt     = IMM_I;
    reg_write_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    branch_o    = 1'b0;
    jal_o       = 1'b0;
    jalr_o      = 1'b0;
    uses_rs1_o  = 1'b0;
    uses_rs2_o  = 1'b0;
    if (valid_i) begin
      case (opcode)
        OPC_OP: begin
          if (op_ok) begin
            alu_op_o    = alu_sel(funct3, funct7[5]);
            reg_write_o = 1'b1;
            uses_rs1_o  = 1'b1;
            uses_rs2_o  = 1'b1;
          end
        end
        OPC_OP_IMM: begin
          if (op_imm_ok) begin
            alu_op_o    = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
            use_imm_o   = 1'b1;
            reg_write_o = 1'b1;
            uses_rs1_o  = 1'b1;
          end
        end
        OPC_LUI, OPC_AUIPC: begin
          alu_op_o    = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_PC_PLUS_B;
          use_imm_o   = 1'b1;
          imm_fmt     = IMM_U;
          reg_write_o = 1'b1;
        end
        OPC_LOAD: begin
          // Word loads only
          if (funct3 == 3'b010) begin
            use_imm_o   = 1'b1;
            reg_write_o = 1'b1;
            mem_read_o  = 1'b1;
            uses_rs1_o  = 1'b1;
          end
        end
        OPC_STORE: begin
          if (funct3 == 3'b010) begin
            use_imm_o   = 1'b1;
            imm_fmt     = IMM_S;
            mem_write_o = 1'b1;
            uses_rs1_o  = 1'b1;
            uses_rs2_o  = 1'b1;
          end
        end
        OPC_BRANCH: begin
          // funct3 010 and 011 are not branches
          if (funct3[2:1] != 2'b01) begin
            imm_fmt    = IMM_B;
            branch_o   = 1'b1;
            uses_rs1_o = 1'b1;
            uses_rs2_o = 1'b1;
          end
        end
        OPC_JAL: begin
          imm_fmt     = IMM_J;
          reg_write_o = 1'b1;
          jal_o       = 1'b1;
        end
        OPC_JALR: begin
          if (funct3 == 3'b000) begin
            use_imm_o   = 1'b1;
            reg_write_o = 1'b1;
            jalr_o      = 1'b1;
            uses_rs1_o  = 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Sign-extended immediate per format
  always_comb begin
    case (imm_fmt)
      IMM_S:   imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      IMM_B:   imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
      IMM_U:   imm_o = {inst_i[31:12], 12'b0};
      IMM_J:   imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};
      default: imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
    endcase
  end

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes handled by the core, anything else is a no-op
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD       = 4'd0,
    ALU_SUB       = 4'd1,
    ALU_SLL       = 4'd2,
    ALU_SLT       = 4'd3,
    ALU_SLTU      = 4'd4,
    ALU_XOR       = 4'd5,
    ALU_SRL       = 4'd6,
    ALU_SRA       = 4'd7,
    ALU_OR        = 4'd8,
    ALU_AND       = 4'd9,
    ALU_PASS_B    = 4'd10,
    ALU_PC_PLUS_B = 4'd11
  } alu_op_e;

  // Encoded as the branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  // Low bit of each instruction field
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

endpackage

// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

  // Datapath and register file sizes
  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [XLEN-1:0] word_t;

  // First fetch address after reset
  localparam word_t RESET_PC = '0;

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

endpackage
